// File: build.f
+incdir+testbench
rtl/m6502_pkg.sv
rtl/m6502_alu.sv
rtl/m6502_addr_unit.sv
rtl/m6502_cpu.sv
rtl/m6502_mem.sv
rtl/m6502_system.sv
testbench/tb_m6502.sv

// File: Makefile
SIM      = verilator
VFLAGS   = --binary --timing
TOP      = tb_m6502
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_m6502_programs.svh
`ifndef TB_M6502_PROGRAMS_SVH
`define TB_M6502_PROGRAMS_SVH

localparam logic [15:0] RESET_VECTOR_ADDR = 16'hFFFC;

localparam int NUM_TESTS = 7;
localparam int F_NAME    = 0;
localparam int F_PROG    = 1;                        // Bytes from 0200 on
localparam int F_DATA    = 2;                        // aaaadd preload words
localparam int F_STORES  = 3;                        // aaaadd stores in order

// Name, program, preloaded data, expected stores
string test_tab [NUM_TESTS][4] = '{
   '{"lda imm sta zp",
     "A9 5A 85 40 A9 C3 85 FF 50 FE",
     "",
     "00405A 00FFC3"},
   '{"zp, zp x, abs, abs x, abs y",
     {"A2 08 A0 10 A5 30 85 80 B5 F9 95 FC AD 34 12 8D 00 03 ",
      "B9 FC 12 99 F8 03 BD F8 20 9D 10 03 50 FE"},
     "003011 000122 123433 130C44 210055",
     "008011 000422 030033 040844 031855"},
   '{"indirect x and indirect y",
     "A2 04 A0 03 A1 20 81 FE B1 30 91 32 B1 FF 85 90 50 FE",
     {"002400 002515 150066 000240 000305 0030F0 003116 ",
      "16F377 0032FE 003305 00FF80 000017 178388"},
     "054066 060177 009088"},
   '{"ora imm, zp, abs x",
     "A9 0F 09 30 85 50 05 60 85 51 A9 81 A2 02 1D 00 40 8D 50 03 50 FE",
     "0060C0 400214",
     "00503F 0051FF 035095"},
   '{"cmp imm and all branches",
     {"A9 40 C9 40 F0 02 85 70 D0 02 85 71 B0 02 85 72 90 02 85 73 ",
      "C9 41 30 02 85 74 10 02 85 75 70 02 85 76 50 02 85 77 85 78 50 FE"},
     "",
     "007140 007340 007540 007640 007840"},
   '{"load flags and cmp zp",
     {"A9 00 F0 02 85 60 85 61 A2 80 30 02 85 62 A9 7F 30 02 85 63 ",
      "C5 10 90 02 85 64 C5 11 B0 02 85 65 30 02 85 66 85 67 50 FE"},
     "001020 001190",
     "006100 00637F 00647F 00657F 00677F"},
   '{"unknown opcodes",
     "A9 3C EA FF 02 69 1A 85 44 DA 4C A9 C5 85 45 50 FE",
     "",
     "00443C 0045C5"}
};

`endif

// File: testbench/tb_m6502.sv
`timescale 1ns/1ps

module tb_m6502;

   localparam int RESET_CYCLES = 8;
   localparam int TEST_CYCLES  = 200;                  // Run budget per test

   logic        clk = 1'b0;
   logic        reset_n;
   logic        load_en;
   logic [15:0] load_addr;
   logic [7:0]  load_data;
   logic        store_valid;
   logic [15:0] store_addr;
   logic [7:0]  store_data;

   logic [23:0] tokens [$];
   int          cycles      = 0;
   int          cycle_limit = 0;
   int          errors      = 0;
   int          checks      = 0;

   `include "tb_m6502_programs.svh"

   m6502_system UUT
   (
      .clk         (clk),
      .reset_n     (reset_n),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .store_valid (store_valid),
      .store_addr  (store_addr),
      .store_data  (store_data)
   );

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("timeout: expected stores not seen");
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [3:0] hex_digit(input logic [7:0] c);
      logic [7:0] v;
      if (c >= 8'h41)                                  // Upper case letter
         v = c - 8'h37;
      else
         v = c - 8'h30;
      return v[3:0];
   endfunction

   // Space separated hex words into tokens
   task automatic split_tokens(input string s);
      logic [23:0] value;
      bit          in_token;
      tokens.delete();
      value    = '0;
      in_token = 1'b0;
      for (int i = 0; i < s.len(); i++)
      begin
         if (s[i] == " ")
         begin
            if (in_token)
               tokens.push_back(value);
            value    = '0;
            in_token = 1'b0;
         end
         else
         begin
            value    = {value[19:0], hex_digit(s[i])};
            in_token = 1'b1;
         end
      end
      if (in_token)
         tokens.push_back(value);
   endtask

   task automatic check_value(input string what, input logic [23:0] actual,
                              input logic [23:0] wanted);
      checks++;
      if (actual !== wanted)
      begin
         errors++;
         $display("FAIL %0t: %s store %h:%h, expected %h:%h", $time, what,
                  actual[23:8], actual[7:0], wanted[23:8], wanted[7:0]);
      end
   endtask

   task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= addr;
      load_data <= data;
   endtask

   task automatic run_test(input int t);
      int base_errors;
      int seen;
      base_errors = errors;
      seen        = 0;
      @(posedge clk);
      reset_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      load_byte(RESET_VECTOR_ADDR, 8'h00);             // Vector to 0200
      load_byte(RESET_VECTOR_ADDR + 16'd1, 8'h02);
      split_tokens(test_tab[t][F_PROG]);
      foreach (tokens[i])
         load_byte(16'h0200 + 16'(i), tokens[i][7:0]);
      split_tokens(test_tab[t][F_DATA]);
      foreach (tokens[i])
         load_byte(tokens[i][23:8], tokens[i][7:0]);
      @(posedge clk);
      load_en <= 1'b0;
      reset_n <= 1'b1;
      split_tokens(test_tab[t][F_STORES]);
      while (seen < tokens.size())
      begin
         @(negedge clk);
         if (store_valid === 1'b1)
         begin
            check_value(test_tab[t][F_NAME], {store_addr, store_data}, tokens[seen]);
            seen++;
         end
      end
      $display("test %0d %s: %0d of %0d stores, %0d errors", t, test_tab[t][F_NAME],
               seen, tokens.size(), errors - base_errors);
   endtask

   initial
   begin
      int limit;
      reset_n   <= 1'b0;
      load_en   <= 1'b0;
      load_addr <= 16'h0000;
      load_data <= 8'h00;
      limit = 0;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         limit += RESET_CYCLES + 4 + TEST_CYCLES;
         split_tokens(test_tab[t][F_PROG]);
         limit += tokens.size();
         split_tokens(test_tab[t][F_DATA]);
         limit += tokens.size();
      end
      cycle_limit = limit;
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: rtl/m6502_system.sv
`timescale 1ns/1ps

module m6502_system
(
   input  logic        clk,
   input  logic        reset_n,
   input  logic        load_en,
   input  logic [15:0] load_addr,
   input  logic [7:0]  load_data,
   output logic        store_valid,
   output logic [15:0] store_addr,
   output logic [7:0]  store_data
);

   logic [15:0] addr;
   logic        rd_req;
   logic        wr_en;
   logic [7:0]  wr_data;
   logic [7:0]  rd_data;
   logic        ready;

   m6502_cpu cpu
   (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   m6502_mem mem
   (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr      (addr),
      .rd_req    (rd_req),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .rd_data   (rd_data),
      .ready     (ready),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   // Memory write port seen from outside
   assign store_valid = wr_en;
   assign store_addr  = addr;
   assign store_data  = wr_data;

endmodule

// File: rtl/m6502_mem.sv
`timescale 1ns/1ps

module m6502_mem import m6502_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  logic [15:0] addr,
   input  logic        rd_req,
   input  logic        wr_en,
   input  logic [7:0]  wr_data,
   output logic [7:0]  rd_data,
   output logic        ready,
   input  logic        load_en,
   input  logic [15:0] load_addr,
   input  logic [7:0]  load_data
);

   logic [7:0]           mem [0:65535];
   logic [MEM_CNT_W-1:0] wait_cnt;

   assign ready = (wait_cnt == '0);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         if (load_en)
            mem[load_addr] <= load_data;               // Preload port
      end
      else if (wr_en)
         mem[addr] <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         wait_cnt <= '0;
      else if (rd_req)
         wait_cnt <= MEM_CNT_W'(MEM_WAIT);
      else if (wait_cnt != '0)
         wait_cnt <= wait_cnt - 1'b1;
   end

   // Byte is captured at the request and held until ready returns
   always_ff @(posedge clk)
   begin
      if (rd_req)
         rd_data <= mem[addr];
   end

endmodule

// File: rtl/m6502_cpu.sv
`timescale 1ns/1ps

module m6502_cpu import m6502_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   output logic [15:0] addr,
   input  logic [7:0]  rd_data,
   output logic [7:0]  wr_data,
   output logic        wr_en,
   output logic        rd_req,
   input  logic        ready
);

   fetch_state_t state;
   logic [15:0]  pc;
   logic [15:0]  pc_op;
   logic [15:0]  next_pc;
   logic [15:0]  branch_offset;
   logic [1:0]   inst_len;
   logic [7:0]   ir;
   logic [7:0]   a;
   logic [7:0]   x;
   logic [7:0]   y;
   logic         fetch_rd_req;
   logic         taken;
   logic         wb_pending;

   addr_mode_t   mode;
   cpu_op_t      op;
   load_store_t  load_store;
   logic         start;
   addr_mode_t   dec_mode;
   cpu_op_t      dec_op;
   load_store_t  dec_ls;

   logic [15:0]  bus_addr;
   logic         bus_rd_req;
   logic [15:0]  vector;
   logic [7:0]   operand;
   logic         done;

   logic         alu_proceed;
   alu_op_t      alu_op;
   logic [7:0]   alu_in_a;
   logic [7:0]   alu_out;
   logic         flag_c;
   logic         flag_z;
   logic         flag_v;
   logic         flag_n;

   // Opcode format aaabbbcc
   always_comb
   begin
      dec_mode = MODE_IDLE;
      dec_op   = OP_NOP;
      dec_ls   = LS_NOTHING;
      if (ir[1:0] == 2'b01)
      begin
         case (ir[7:5])
            3'b000:  dec_op = OP_ORA;
            3'b101:  dec_op = OP_LD;
            3'b110:  dec_op = OP_CMP;
            default: dec_op = OP_NOP;
         endcase
         if (ir[7:5] == 3'b100)
            dec_ls = LS_STORE;                          // STA
         else if (dec_op != OP_NOP)
            dec_ls = LS_LOAD;
         if (dec_ls != LS_NOTHING)
         begin
            case (ir[4:2])
               3'd0:    dec_mode = MODE_IND_X;
               3'd1:    dec_mode = MODE_Z;
               3'd2:    dec_mode = MODE_IMM;
               3'd3:    dec_mode = MODE_ABS;
               3'd4:    dec_mode = MODE_IND_Y;
               3'd5:    dec_mode = MODE_Z_X;
               3'd6:    dec_mode = MODE_ABS_Y;
               default: dec_mode = MODE_ABS_X;
            endcase
         end
      end
      else if (ir[4:0] == 5'b10000)
      begin
         dec_op   = OP_BRANCH;
         dec_mode = MODE_IMM;
         dec_ls   = LS_LOAD;
      end
      else if (ir == 8'hA2 || ir == 8'hA0)
      begin
         dec_op   = (ir[1]) ? OP_LDX : OP_LDY;
         dec_mode = MODE_IMM;
         dec_ls   = LS_LOAD;
      end
   end

   always_comb
   begin
      case (ir[7:5])
         3'b000:  taken = !flag_n;                      // BPL
         3'b001:  taken = flag_n;                       // BMI
         3'b010:  taken = !flag_v;                      // BVC
         3'b011:  taken = flag_v;                       // BVS
         3'b100:  taken = !flag_c;                      // BCC
         3'b101:  taken = flag_c;                       // BCS
         3'b110:  taken = !flag_z;                      // BNE
         default: taken = flag_z;                       // BEQ
      endcase
   end

   always_comb
   begin
      case (mode)
         MODE_ABS, MODE_ABS_X, MODE_ABS_Y: inst_len = 2'd3;
         MODE_IDLE:                        inst_len = 2'd1;
         default:                          inst_len = 2'd2;
      endcase
   end

   assign pc_op         = pc + 16'd1;
   assign branch_offset = taken ? {{8{operand[7]}}, operand} : 16'd0;

   always_comb
   begin
      if (mode == MODE_RESET)
         next_pc = vector;
      else if (op == OP_BRANCH)
         next_pc = pc + 16'd2 + branch_offset;
      else
         next_pc = pc + {14'd0, inst_len};
   end

   always_ff @(posedge clk)
   begin
      fetch_rd_req <= 1'b0;
      start        <= 1'b0;
      wb_pending   <= 1'b0;
      if (!reset_n)
      begin
         state      <= FS_WAIT;
         mode       <= MODE_IDLE;
         op         <= OP_NOP;
         load_store <= LS_NOTHING;
         a          <= 8'h00;
         x          <= 8'h00;
         y          <= 8'h00;
      end
      else
      begin
         case (state)
            FS_WAIT:
               state <= FS_RESET;
            FS_RESET:
            begin
               mode       <= MODE_RESET;                // Vector read
               op         <= OP_NOP;
               load_store <= LS_LOAD;
               start      <= 1'b1;
               state      <= FS_EXECUTE_WAIT;
            end
            FS_FETCH:
               if (ready && !fetch_rd_req)
               begin
                  ir    <= rd_data;
                  state <= FS_EXECUTE;
               end
            FS_EXECUTE:
            begin
               mode       <= dec_mode;
               op         <= dec_op;
               load_store <= dec_ls;
               start      <= 1'b1;
               state      <= FS_EXECUTE_WAIT;
            end
            FS_EXECUTE_WAIT:
               if (done)
               begin
                  pc           <= next_pc;
                  fetch_rd_req <= 1'b1;
                  wb_pending   <= 1'b1;
                  state        <= FS_FETCH;
               end
            default:
               state <= FS_WAIT;
         endcase
         // ALU result lands one cycle after done, during the next fetch
         if (wb_pending)
         begin
            case (op)
               OP_LD, OP_ORA: a <= alu_out;
               OP_LDX:        x <= alu_out;
               OP_LDY:        y <= alu_out;
               default:       a <= a;
            endcase
         end
      end
   end

   assign addr   = fetch_rd_req ? pc : bus_addr;
   assign rd_req = fetch_rd_req | bus_rd_req;

   m6502_addr_unit addr_unit
   (
      .clk         (clk),
      .reset_n     (reset_n),
      .ready       (ready),
      .rd_data     (rd_data),
      .start       (start),
      .mode        (mode),
      .op          (op),
      .load_store  (load_store),
      .pc_op       (pc_op),
      .x           (x),
      .y           (y),
      .write_data  (a),
      .bus_addr    (bus_addr),
      .bus_rd_req  (bus_rd_req),
      .bus_wr_en   (wr_en),
      .bus_wr_data (wr_data),
      .alu_proceed (alu_proceed),
      .alu_op      (alu_op),
      .alu_in_a    (alu_in_a),
      .a           (a),
      .operand     (operand),
      .vector      (vector),
      .done        (done)
   );

   m6502_alu alu
   (
      .clk     (clk),
      .reset_n (reset_n),
      .proceed (alu_proceed),
      .op      (alu_op),
      .in_a    (alu_in_a),
      .in_b    (operand),
      .out     (alu_out),
      .flag_c  (flag_c),
      .flag_z  (flag_z),
      .flag_v  (flag_v),
      .flag_n  (flag_n)
   );

endmodule

// File: rtl/m6502_addr_unit.sv
`timescale 1ns/1ps

module m6502_addr_unit import m6502_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  logic        ready,
   input  logic [7:0]  rd_data,
   input  logic        start,
   input  addr_mode_t  mode,
   input  cpu_op_t     op,
   input  load_store_t load_store,
   input  logic [15:0] pc_op,
   input  logic [7:0]  x,
   input  logic [7:0]  y,
   input  logic [7:0]  write_data,
   output logic [15:0] bus_addr,
   output logic        bus_rd_req,
   output logic        bus_wr_en,
   output logic [7:0]  bus_wr_data,
   output logic        alu_proceed,
   output alu_op_t     alu_op,
   output logic [7:0]  alu_in_a,
   input  logic [7:0]  a,
   output logic [7:0]  operand,
   output logic [15:0] vector,
   output logic        done
);

   typedef enum logic [3:0]
   {
      S_IDLE,
      S_VEC_LO,
      S_VEC_HI,
      S_ZP,
      S_ABS_LO,
      S_ABS_HI,
      S_IND,
      S_PTR_LO,
      S_PTR_HI,
      S_FINAL
   } step_t;

   step_t       step;
   logic [7:0]  lo;
   logic [7:0]  index;
   logic [7:0]  ptr;
   logic [15:0] eff_addr;
   logic        data_ok;

   // Read data is valid once ready is back and no request is in this cycle
   assign data_ok = ready && !bus_rd_req;

   always_comb
   begin
      case (mode)
         MODE_Z_X, MODE_ABS_X:             index = x;
         MODE_Z_Y, MODE_ABS_Y, MODE_IND_Y: index = y;
         default:                          index = 8'h00;
      endcase
   end

   assign ptr = rd_data + ((mode == MODE_IND_X) ? x : 8'h00);   // Stays in page 0

   always_comb
   begin
      if (step == S_ZP)
         eff_addr = {8'h00, rd_data + index};          // Zero page wrap
      else
         eff_addr = {rd_data, lo} + {8'h00, index};
   end

   always_ff @(posedge clk)
   begin
      bus_rd_req  <= 1'b0;
      bus_wr_en   <= 1'b0;
      alu_proceed <= 1'b0;
      done        <= 1'b0;
      if (!reset_n)
      begin
         step <= S_IDLE;
      end
      else
      begin
         case (step)
            S_IDLE:
               if (start)
               begin
                  if (mode == MODE_IDLE)
                     done <= 1'b1;
                  else
                  begin
                     bus_rd_req <= 1'b1;
                     bus_addr   <= (mode == MODE_RESET) ? RESET_VECTOR : pc_op;
                     case (mode)
                        MODE_RESET:                       step <= S_VEC_LO;
                        MODE_IMM:                         step <= S_FINAL;
                        MODE_Z, MODE_Z_X, MODE_Z_Y:       step <= S_ZP;
                        MODE_ABS, MODE_ABS_X, MODE_ABS_Y: step <= S_ABS_LO;
                        default:                          step <= S_IND;
                     endcase
                  end
               end
            S_VEC_LO, S_ABS_LO:
               if (data_ok)
               begin
                  lo         <= rd_data;
                  bus_rd_req <= 1'b1;
                  bus_addr   <= (step == S_VEC_LO) ? bus_addr + 16'd1 : pc_op + 16'd1;
                  step       <= (step == S_VEC_LO) ? S_VEC_HI : S_ABS_HI;
               end
            S_VEC_HI:
               if (data_ok)
               begin
                  vector <= {rd_data, lo};
                  done   <= 1'b1;
                  step   <= S_IDLE;
               end
            S_IND:
               if (data_ok)
               begin
                  bus_addr   <= {8'h00, ptr};
                  bus_rd_req <= 1'b1;
                  step       <= S_PTR_LO;
               end
            S_PTR_LO:
               if (data_ok)
               begin
                  lo         <= rd_data;
                  bus_addr   <= {8'h00, bus_addr[7:0] + 8'd1};   // High byte also in page 0
                  bus_rd_req <= 1'b1;
                  step       <= S_PTR_HI;
               end
            S_ZP, S_ABS_HI, S_PTR_HI:
               if (data_ok)
               begin
                  bus_addr <= eff_addr;
                  if (load_store == LS_STORE)
                  begin
                     bus_wr_en   <= 1'b1;
                     bus_wr_data <= write_data;
                     done        <= 1'b1;                // Write finishes this cycle
                     step        <= S_IDLE;
                  end
                  else
                  begin
                     bus_rd_req <= 1'b1;
                     step       <= S_FINAL;
                  end
               end
            S_FINAL:
               if (data_ok)
               begin
                  operand <= rd_data;
                  done    <= 1'b1;
                  step    <= S_IDLE;
                  case (op)
                     OP_LD, OP_LDX, OP_LDY:
                     begin
                        alu_proceed <= 1'b1;
                        alu_op      <= ALU_UPDATE;
                        alu_in_a    <= rd_data;
                     end
                     OP_ORA, OP_CMP:
                     begin
                        alu_proceed <= 1'b1;
                        alu_op      <= (op == OP_ORA) ? ALU_OR : ALU_CMP;
                        alu_in_a    <= a;
                     end
                     default:
                        alu_proceed <= 1'b0;             // Branch offset only
                  endcase
               end
            default:
               step <= S_IDLE;
         endcase
      end
   end

endmodule

// File: rtl/m6502_alu.sv
`timescale 1ns/1ps

module m6502_alu import m6502_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic       proceed,
   input  alu_op_t    op,
   input  logic [7:0] in_a,
   input  logic [7:0] in_b,
   output logic [7:0] out,
   output logic       flag_c,
   output logic       flag_z,
   output logic       flag_v,
   output logic       flag_n
);

   logic [8:0] diff;
   logic [7:0] result;

   assign diff = {1'b0, in_a} - {1'b0, in_b};

   always_comb
   begin
      case (op)
         ALU_OR:  result = in_a | in_b;
         ALU_CMP: result = diff[7:0];
         default: result = in_a;                  // Plain load
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_c <= 1'b0;
         flag_z <= 1'b0;
         flag_n <= 1'b0;
      end
      else if (proceed)
      begin
         out    <= result;
         flag_z <= (result == 8'h00);
         flag_n <= result[7];
         if (op == ALU_CMP)
            flag_c <= !diff[8];                 // No borrow, in_a >= in_b
      end
   end

   // No ADC/SBC here, so overflow never sets
   assign flag_v = 1'b0;

endmodule

// File: rtl/m6502_pkg.sv
package m6502_pkg;

   typedef enum logic [2:0]
   {
      FS_WAIT,
      FS_RESET,
      FS_FETCH,
      FS_EXECUTE,
      FS_EXECUTE_WAIT
   } fetch_state_t;

   typedef enum logic [3:0]
   {
      MODE_IDLE,
      MODE_RESET,
      MODE_IMM,
      MODE_Z,
      MODE_Z_X,
      MODE_Z_Y,
      MODE_ABS,
      MODE_ABS_X,
      MODE_ABS_Y,
      MODE_IND_X,
      MODE_IND_Y
   } addr_mode_t;

   typedef enum logic [1:0]
   {
      LS_NOTHING,
      LS_LOAD,
      LS_STORE
   } load_store_t;

   typedef enum logic [1:0]
   {
      ALU_UPDATE,
      ALU_OR,
      ALU_CMP
   } alu_op_t;

   typedef enum logic [2:0]
   {
      OP_NOP,
      OP_LD,
      OP_ORA,
      OP_CMP,
      OP_BRANCH,
      OP_LDX,
      OP_LDY
   } cpu_op_t;

   localparam logic [15:0] RESET_VECTOR = 16'hFFFC;
   localparam int          MEM_WAIT     = 1;
   localparam int          MEM_CNT_W    = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

endpackage
